// File: Bender.yml
package:
  name: bp_predictor

sources:
  - files:
      - hdl/bp_pkg.sv
      - hdl/bp_update_if.sv
      - hdl/bp_init_fsm.sv
      - hdl/bp_pht.sv
      - hdl/bp_btb.sv
      - hdl/bp_predictor_top.sv
  - target: test
    files:
      - bench/bp_tb.sv

// File: bench/bp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bp_tb;

    localparam int PERIOD     = 20;
    localparam int NUM_BTB    = 16;
    localparam int GHR_BITS   = 5;
    localparam int IDX_W      = 4;
    localparam int PHT_DEPTH  = 32;
    localparam int WALK_LEN   = 32;
    localparam int ROW_CYCLES = 4;
    localparam int NUM_RANDOM = 48;
    localparam logic [31:0] SEED = 32'h777b_2690;

    // one table row, op only matters for lookups and the update fields only for updates
    typedef struct packed {
        logic        upd;
        logic [31:0] pc;
        logic [6:0]  op;
        logic [31:0] target;
        logic        taken;
        logic        is_cond;
        logic        is_jump;
    } row_t;

    logic                clk;
    logic                reset_i;
    logic [31:0]         pc_i;
    logic [6:0]          op_i;
    logic [31:0]         next_pc_o;
    logic                taken_o;
    logic [GHR_BITS-1:0] pht_index_o;
    logic                upd_valid_i;
    logic                upd_ready_o;
    logic [31:0]         upd_pc_i;
    logic [31:0]         upd_target_i;
    logic                upd_taken_i;
    logic                upd_is_cond_i;
    logic                upd_is_jump_i;
    logic [GHR_BITS-1:0] upd_pht_index_i;

    // reference model of both tables and the history
    logic                m_valid  [NUM_BTB];
    logic [31:IDX_W+2]   m_tag    [NUM_BTB];
    logic                m_kind   [NUM_BTB];
    logic [31:0]         m_target [NUM_BTB];
    logic [1:0]          m_ctr    [PHT_DEPTH];
    logic [GHR_BITS-1:0] m_ghr;

    row_t        rows[$];
    int          errors;
    int          checks;
    int          walk_cycles;
    int unsigned seed_val;
    bit          built;

    bp_predictor_top #(
        .NUM_BTB_ENTRIES (NUM_BTB),
        .NUM_GHR_BITS    (GHR_BITS)
    ) dut0 (
        .clk             (clk),
        .reset_i         (reset_i),
        .pc_i            (pc_i),
        .op_i            (op_i),
        .next_pc_o       (next_pc_o),
        .taken_o         (taken_o),
        .pht_index_o     (pht_index_o),
        .upd_valid_i     (upd_valid_i),
        .upd_ready_o     (upd_ready_o),
        .upd_pc_i        (upd_pc_i),
        .upd_target_i    (upd_target_i),
        .upd_taken_i     (upd_taken_i),
        .upd_is_cond_i   (upd_is_cond_i),
        .upd_is_jump_i   (upd_is_jump_i),
        .upd_pht_index_i (upd_pht_index_i)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic lookup(input logic [31:0] pc, input logic [6:0] op);
        rows.push_back(row_t'{1'b0, pc, op, 32'h0, 1'b0, 1'b0, 1'b0});
    endtask

    task automatic resolve(input logic [31:0] pc, input logic [31:0] target,
                           input logic taken, input logic is_cond, input logic is_jump);
        rows.push_back(row_t'{1'b1, pc, 7'h0, target, taken, is_cond, is_jump});
    endtask

    // gshare index, history XOR the word address bits of the PC
    function automatic logic [GHR_BITS-1:0] model_index(input logic [31:0] pc);
        return m_ghr ^ pc[GHR_BITS+1:2];
    endfunction

    // a taken transfer fills the BTB, a conditional branch trains and shifts history
    task automatic train_model(input row_t r, input logic [GHR_BITS-1:0] idx);
        logic [IDX_W-1:0] b;
        b = r.pc[IDX_W+1:2];
        if (r.taken) begin
            m_valid[b]  = 1'b1;
            m_tag[b]    = r.pc[31:IDX_W+2];
            m_target[b] = r.target;
            m_kind[b]   = r.is_jump;
        end
        if (r.is_cond) begin
            if (r.taken && m_ctr[idx] != bp_pkg::CTR_ST) begin
                m_ctr[idx] = m_ctr[idx] + 2'd1;
            end else if (!r.taken && m_ctr[idx] != bp_pkg::CTR_SNT) begin
                m_ctr[idx] = m_ctr[idx] - 2'd1;
            end
            m_ghr = {m_ghr[GHR_BITS-2:0], r.taken};
        end
    endtask

    // hold the update until ready, the model follows at the transfer edge
    task automatic apply_update(input row_t r);
        logic [GHR_BITS-1:0] idx;
        @(negedge clk);
        idx             = model_index(r.pc);
        upd_valid_i     = 1'b1;
        upd_pc_i        = r.pc;
        upd_target_i    = r.target;
        upd_taken_i     = r.taken;
        upd_is_cond_i   = r.is_cond;
        upd_is_jump_i   = r.is_jump;
        upd_pht_index_i = idx;
        while (!upd_ready_o) @(negedge clk);
        @(posedge clk);
        train_model(r, idx);
    endtask

    task automatic check_predict(input row_t r);
        logic [IDX_W-1:0]    b;
        logic                hit;
        logic                exp_taken;
        logic [31:0]         exp_next;
        logic [GHR_BITS-1:0] exp_index;
        @(negedge clk);
        upd_valid_i = 1'b0;
        pc_i        = r.pc;
        op_i        = r.op;
        b           = r.pc[IDX_W+1:2];
        hit         = m_valid[b] && (m_tag[b] == r.pc[31:IDX_W+2]);
        exp_index   = model_index(r.pc);
        // a jump entry needs a jump opcode, a branch entry a branch opcode and a taken counter
        exp_taken = hit && ((m_kind[b] && (r.op == bp_pkg::OP_JAL || r.op == bp_pkg::OP_JALR))
                    || (!m_kind[b] && r.op == bp_pkg::OP_BRANCH && m_ctr[exp_index][1]));
        exp_next  = exp_taken ? m_target[b] : r.pc + 32'd4;
        // the prediction path is combinational, so sample mid low phase
        #(PERIOD / 4);
        checks += 3;
        assert (taken_o === exp_taken) else begin
            $display("CHECK FAILED taken_o pc=%h expected %h got %h", r.pc, exp_taken, taken_o);
            errors++;
        end
        assert (next_pc_o === exp_next) else begin
            $display("CHECK FAILED next_pc_o pc=%h expected %h got %h", r.pc, exp_next, next_pc_o);
            errors++;
        end
        assert (pht_index_o === exp_index) else begin
            $display("CHECK FAILED pht_index_o pc=%h expected %h got %h",
                     r.pc, exp_index, pht_index_o);
            errors++;
        end
    endtask

    task automatic build_table();
        logic [31:0] pool [8];
        logic [31:0] pc;
        int          pick;
        // nothing is stored yet, so every lookup falls through
        lookup(32'h0000_0100, bp_pkg::OP_BRANCH);
        lookup(32'h0000_1004, bp_pkg::OP_JAL);
        // jump fills the BTB and is taken on the next lookup
        resolve(32'h0000_1004, 32'h0000_2000, 1'b1, 1'b0, 1'b1);
        lookup(32'h0000_1004, bp_pkg::OP_JAL);
        // taken branches fill the history with ones, then push one counter to saturation
        for (int k = 0; k < 8; k++) begin
            resolve(32'h0000_1048, 32'h0000_1080, 1'b1, 1'b1, 1'b0);
            lookup(32'h0000_1048, bp_pkg::OP_BRANCH);
        end
        // not taken ones clear the history, then walk one counter down to the floor
        for (int k = 0; k < 8; k++) begin
            resolve(32'h0000_1048, 32'h0000_1080, 1'b0, 1'b1, 1'b0);
            lookup(32'h0000_1048, bp_pkg::OP_BRANCH);
        end
        // a jump leaves the history where it was
        resolve(32'h0000_3008, 32'h0000_0040, 1'b1, 1'b0, 1'b1);
        lookup(32'h0000_3008, bp_pkg::OP_JALR);
        lookup(32'h0000_1048, bp_pkg::OP_BRANCH);
        // same index as 0x1004 with another tag, misses until it takes the slot over
        lookup(32'h0000_5004, bp_pkg::OP_JAL);
        resolve(32'h0000_5004, 32'h0000_5100, 1'b1, 1'b0, 1'b1);
        lookup(32'h0000_5004, bp_pkg::OP_JAL);
        lookup(32'h0000_1004, bp_pkg::OP_JAL);
        // a 1 KiB pool gives index collisions between different tags
        for (int k = 0; k < 8; k++) begin
            pool[k] = 32'h0000_8000 + ($urandom_range(255, 0) << 2);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            pc   = pool[$urandom_range(7, 0)];
            pick = $urandom_range(4, 0);
            if (pick == 0) begin
                resolve(pc, $urandom & 32'hffff_fffc, 1'b1, 1'b0, 1'b1);
            end else if (pick == 1) begin
                resolve(pc, $urandom & 32'hffff_fffc, 1'($urandom_range(1, 0)), 1'b1, 1'b0);
            end else if (pick == 2) begin
                lookup(pc, bp_pkg::OP_JAL);
            end else begin
                lookup(pc, bp_pkg::OP_BRANCH);
            end
        end
    endtask

    initial begin
        seed_val        = $urandom(SEED);
        reset_i         = 1'b1;
        pc_i            = '0;
        op_i            = '0;
        upd_valid_i     = 1'b0;
        upd_pc_i        = '0;
        upd_target_i    = '0;
        upd_taken_i     = 1'b0;
        upd_is_cond_i   = 1'b0;
        upd_is_jump_i   = 1'b0;
        upd_pht_index_i = '0;
        errors          = 0;
        checks          = 0;
        for (int k = 0; k < NUM_BTB; k++) begin
            m_valid[k] = 1'b0;
        end
        for (int k = 0; k < PHT_DEPTH; k++) begin
            m_ctr[k] = bp_pkg::CTR_WNT;
        end
        m_ghr = '0;
        build_table();
        built = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        // an update with no effect is offered during the whole walk
        upd_valid_i = 1'b1;
        walk_cycles = 0;
        while (!upd_ready_o) begin
            walk_cycles++;
            @(negedge clk);
        end
        assert (walk_cycles == WALK_LEN) else begin
            $display("update ready rose after %0d cycles of the walk instead of %0d",
                     walk_cycles, WALK_LEN);
            errors++;
        end
        @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].upd) begin
                apply_update(rows[i]);
            end else begin
                check_predict(rows[i]);
            end
        end
        @(negedge clk);
        upd_valid_i = 1'b0;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // every row gets a few cycles on top of reset and the walk
    initial begin
        wait (built);
        #((rows.size() * ROW_CYCLES + WALK_LEN + 10) * PERIOD);
        $display("timeout: the run did not finish in the time allowed for %0d rows",
                 rows.size());
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/bp_pkg.sv
hdl/bp_update_if.sv
hdl/bp_init_fsm.sv
hdl/bp_pht.sv
hdl/bp_btb.sv
hdl/bp_predictor_top.sv
bench/bp_tb.sv

// File: hdl/bp_btb.sv
`timescale 1ns/1ps
`default_nettype none

// direct mapped branch target buffer
// each entry holds a valid bit, a tag, a kind and the taken target
module bp_btb #(
    parameter int NUM_BTB_ENTRIES = 16,
    parameter int CLEAR_W         = 5
) (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    bp_update_if.consumer                  upd,
    input  wire logic                      clear_i,
    input  wire logic [CLEAR_W-1:0]        clear_index_i,
    input  wire logic [bp_pkg::XLEN-1:0]   pc_i,
    output      logic                      hit_o,
    output      bp_pkg::btb_kind_e         kind_o,
    output      logic [bp_pkg::XLEN-1:0]   target_o
);

    localparam int IDX_W = $clog2(NUM_BTB_ENTRIES);
    localparam int TAG_W = bp_pkg::XLEN - IDX_W - 2;

    logic                      valid_q  [NUM_BTB_ENTRIES];
    logic [TAG_W-1:0]          tag_q    [NUM_BTB_ENTRIES];
    bp_pkg::btb_kind_e         kind_q   [NUM_BTB_ENTRIES];
    logic [bp_pkg::XLEN-1:0]   target_q [NUM_BTB_ENTRIES];

    logic [IDX_W-1:0]          rd_idx;
    logic [TAG_W-1:0]          rd_tag;
    logic [IDX_W-1:0]          wr_idx;
    logic [TAG_W-1:0]          wr_tag;
    logic                      wr_en;

    // index and tag split as stated in bp_pkg, for lookup and for writes
    assign rd_idx = pc_i[IDX_W+1:2];
    assign rd_tag = pc_i[bp_pkg::XLEN-1:IDX_W+2];
    assign wr_idx = upd.pc[IDX_W+1:2];
    assign wr_tag = upd.pc[bp_pkg::XLEN-1:IDX_W+2];

    // only taken transfers are worth a slot, a not taken branch leaves the entry alone
    assign wr_en = upd.valid && upd.ready && upd.taken;

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign kind_o   = kind_q[rd_idx];
    assign target_o = target_q[rd_idx];

    // valid bits are cleared by the walk
    // indices past our depth are skipped when the PHT is the longer table
    always_ff @(posedge clk) begin
        if (clear_i) begin
            if (clear_index_i <= CLEAR_W'(NUM_BTB_ENTRIES - 1)) begin
                valid_q[clear_index_i[IDX_W-1:0]] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // a new taken transfer simply overwrites whatever sat at that index
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd.target;
            kind_q[wr_idx]   <= upd.is_jump ? bp_pkg::KIND_JUMP : bp_pkg::KIND_BRANCH;
        end
    end

    // execute classifies each instruction as one kind at most
    a_one_kind: assert property (
        @(posedge clk) disable iff (reset_i)
        upd.valid |-> !(upd.is_cond && upd.is_jump)
    );

endmodule

`default_nettype wire

// File: hdl/bp_init_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// walks every table index once after reset, one per cycle
// update ready stays low until the walk has finished
module bp_init_fsm #(
    parameter int WALK_LEN = 32,
    parameter int CLEAR_W  = 5
) (
    input  wire logic                clk,
    input  wire logic                reset_i,
    bp_update_if.ready_drv           upd,
    output      logic                clear_o,
    output      logic [CLEAR_W-1:0]  clear_index_o
);

    typedef enum logic {
        WALK = 1'b0,
        RUN  = 1'b1
    } state_e;

    state_e             state_q;
    logic [CLEAR_W-1:0] walk_idx_q;
    logic               walk_last;

    // the last index of the longer table ends the walk
    assign walk_last = (walk_idx_q == CLEAR_W'(WALK_LEN - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= WALK;
            walk_idx_q <= '0;
        end else begin
            case (state_q)
                WALK: begin
                    walk_idx_q <= walk_idx_q + 1'b1;
                    if (walk_last) begin
                        state_q <= RUN;
                    end
                end
                // once running we never go back, only a reset restarts the walk
                default: begin
                    state_q <= RUN;
                end
            endcase
        end
    end

    // both tables write the init value at clear_index_o while clear_o is high
    assign clear_o       = (state_q == WALK);
    assign clear_index_o = walk_idx_q;

    // ready depends on the state only and never on valid
    assign upd.ready = (state_q == RUN);

    // a table write from an update must never race a clear write
    a_clear_excludes_ready: assert property (
        @(posedge clk) !(clear_o && upd.ready)
    );

endmodule

`default_nettype wire

// File: hdl/bp_pht.sv
`timescale 1ns/1ps
`default_nettype none

// gshare direction predictor: a table of 2 bit counters and the global history
module bp_pht #(
    parameter int NUM_GHR_BITS = 5,
    parameter int CLEAR_W      = 5
) (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    bp_update_if.consumer                  upd,
    input  wire logic                      clear_i,
    input  wire logic [CLEAR_W-1:0]        clear_index_i,
    input  wire logic [bp_pkg::XLEN-1:0]   pc_i,
    output      logic [NUM_GHR_BITS-1:0]   index_o,
    output      logic                      taken_o
);

    localparam int PHT_DEPTH = 1 << NUM_GHR_BITS;

    bp_pkg::ctr_t            pht_q [PHT_DEPTH];
    logic [NUM_GHR_BITS-1:0] ghr_q;
    logic [NUM_GHR_BITS-1:0] rd_index;
    logic                    upd_fire;
    bp_pkg::ctr_t            ctr_cur;
    bp_pkg::ctr_t            ctr_nxt;

    // hash the global history with the word address bits of the fetch PC
    assign rd_index = ghr_q ^ pc_i[NUM_GHR_BITS+1:2];
    assign index_o  = rd_index;
    assign taken_o  = pht_q[rd_index][1];

    assign upd_fire = upd.valid && upd.ready;

    // training uses the index from prediction time, not a fresh hash
    // the GHR has moved on since then
    assign ctr_cur = pht_q[upd.pht_index];

    always_comb begin
        ctr_nxt = ctr_cur;
        if (upd.taken) begin
            if (ctr_cur != bp_pkg::CTR_ST) begin
                ctr_nxt = ctr_cur + 2'd1;
            end
        end else begin
            if (ctr_cur != bp_pkg::CTR_SNT) begin
                ctr_nxt = ctr_cur - 2'd1;
            end
        end
    end

    // the walk may run past our depth when the BTB is larger
    always_ff @(posedge clk) begin
        if (clear_i) begin
            if (clear_index_i <= CLEAR_W'(PHT_DEPTH - 1)) begin
                pht_q[clear_index_i[NUM_GHR_BITS-1:0]] <= bp_pkg::CTR_WNT;
            end
        end else if (upd_fire && upd.is_cond) begin
            pht_q[upd.pht_index] <= ctr_nxt;
        end
    end

    // only conditional branches shift history, the newest outcome goes in at the bottom
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
        end else if (upd_fire && upd.is_cond) begin
            ghr_q <= {ghr_q[NUM_GHR_BITS-2:0], upd.taken};
        end
    end

    // every counter was set by the walk, so training never sees an unknown
    a_ctr_defined: assert property (
        @(posedge clk) disable iff (reset_i)
        (upd_fire && upd.is_cond) |-> !$isunknown(ctr_cur)
    );

    // the FSM holds updates off for the whole walk
    a_no_update_while_clear: assert property (
        @(posedge clk) disable iff (reset_i) !(upd_fire && clear_i)
    );

endmodule

`default_nettype wire

// File: hdl/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // address width of the fetch and resolved PCs
    localparam int XLEN = 32;

    // major opcodes of the control transfer instructions we care about
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // two bit saturating direction counter, the upper bit is the taken prediction
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_SNT = 2'b00;
    localparam ctr_t CTR_WNT = 2'b01;
    localparam ctr_t CTR_WT  = 2'b10;
    localparam ctr_t CTR_ST  = 2'b11;

    // what kind of instruction filled a BTB entry
    // a jump entry is always taken, a branch entry defers to the counter
    typedef enum logic {
        KIND_BRANCH = 1'b0,
        KIND_JUMP   = 1'b1
    } btb_kind_e;

    // BTB index rule, with IDX_W = $clog2(NUM_BTB_ENTRIES)
    // pc[1:0] is the byte offset and never takes part in a lookup
    // pc[IDX_W+1:2] selects the entry
    // pc[XLEN-1:IDX_W+2] is the tag stored and compared in that entry
    // the PHT index uses the same offset, GHR ^ pc[NUM_GHR_BITS+1:2]

endpackage

`default_nettype wire

// File: hdl/bp_predictor_top.sv
`timescale 1ns/1ps
`default_nettype none

// front end branch predictor, a BTB for targets and gshare for direction
module bp_predictor_top #(
    parameter int NUM_BTB_ENTRIES = 16,
    parameter int NUM_GHR_BITS    = 5
) (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic [bp_pkg::XLEN-1:0]   pc_i,
    input  wire logic [6:0]                op_i,
    output      logic [bp_pkg::XLEN-1:0]   next_pc_o,
    output      logic                      taken_o,
    output      logic [NUM_GHR_BITS-1:0]   pht_index_o,
    input  wire logic                      upd_valid_i,
    output      logic                      upd_ready_o,
    input  wire logic [bp_pkg::XLEN-1:0]   upd_pc_i,
    input  wire logic [bp_pkg::XLEN-1:0]   upd_target_i,
    input  wire logic                      upd_taken_i,
    input  wire logic                      upd_is_cond_i,
    input  wire logic                      upd_is_jump_i,
    input  wire logic [NUM_GHR_BITS-1:0]   upd_pht_index_i
);

    // the walk covers whichever table is deeper
    localparam int PHT_DEPTH = 1 << NUM_GHR_BITS;
    localparam int WALK_LEN  = (NUM_BTB_ENTRIES > PHT_DEPTH) ? NUM_BTB_ENTRIES : PHT_DEPTH;
    localparam int CLEAR_W   = $clog2(WALK_LEN);

    logic                      clear;
    logic [CLEAR_W-1:0]        clear_index;
    logic                      pht_taken;
    logic                      btb_hit;
    bp_pkg::btb_kind_e         btb_kind;
    logic [bp_pkg::XLEN-1:0]   btb_target;
    logic                      is_branch_op;
    logic                      is_jump_op;
    logic                      jump_taken;
    logic                      branch_taken;

    bp_update_if #(.NUM_GHR_BITS(NUM_GHR_BITS)) upd_bus ();

    // the update ports are bundled here and seen by every block below
    assign upd_bus.valid     = upd_valid_i;
    assign upd_bus.pc        = upd_pc_i;
    assign upd_bus.target    = upd_target_i;
    assign upd_bus.taken     = upd_taken_i;
    assign upd_bus.is_cond   = upd_is_cond_i;
    assign upd_bus.is_jump   = upd_is_jump_i;
    assign upd_bus.pht_index = upd_pht_index_i;
    assign upd_ready_o       = upd_bus.ready;

    bp_init_fsm #(
        .WALK_LEN (WALK_LEN),
        .CLEAR_W  (CLEAR_W)
    ) u_init_fsm (
        .clk           (clk),
        .reset_i       (reset_i),
        .upd           (upd_bus.ready_drv),
        .clear_o       (clear),
        .clear_index_o (clear_index)
    );

    bp_pht #(
        .NUM_GHR_BITS (NUM_GHR_BITS),
        .CLEAR_W      (CLEAR_W)
    ) u_pht (
        .clk           (clk),
        .reset_i       (reset_i),
        .upd           (upd_bus.consumer),
        .clear_i       (clear),
        .clear_index_i (clear_index),
        .pc_i          (pc_i),
        .index_o       (pht_index_o),
        .taken_o       (pht_taken)
    );

    bp_btb #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES),
        .CLEAR_W         (CLEAR_W)
    ) u_btb (
        .clk           (clk),
        .reset_i       (reset_i),
        .upd           (upd_bus.consumer),
        .clear_i       (clear),
        .clear_index_i (clear_index),
        .pc_i          (pc_i),
        .hit_o         (btb_hit),
        .kind_o        (btb_kind),
        .target_o      (btb_target)
    );

    assign is_branch_op = (op_i == bp_pkg::OP_BRANCH);
    assign is_jump_op   = (op_i == bp_pkg::OP_JAL) || (op_i == bp_pkg::OP_JALR);

    // the stored kind must agree with the opcode class, which guards against
    // an entry left behind by a different instruction at the same PC
    assign jump_taken   = btb_hit && is_jump_op && (btb_kind == bp_pkg::KIND_JUMP);
    assign branch_taken = btb_hit && is_branch_op && (btb_kind == bp_pkg::KIND_BRANCH)
                          && pht_taken;

    // everything else falls through to the next sequential instruction
    assign taken_o   = jump_taken || branch_taken;
    assign next_pc_o = taken_o ? btb_target : (pc_i + bp_pkg::XLEN'(4));

endmodule

`default_nettype wire

// File: hdl/bp_update_if.sv
`timescale 1ns/1ps
`default_nettype none

// one resolved branch outcome coming back from execute
// a transfer happens on a rising edge with valid and ready both high
interface bp_update_if #(
    parameter int NUM_GHR_BITS = 5
) ();

    logic                      valid;
    logic                      ready;
    logic [bp_pkg::XLEN-1:0]   pc;
    logic [bp_pkg::XLEN-1:0]   target;
    logic                      taken;
    logic                      is_cond;
    logic                      is_jump;
    // the counter index handed out when this instruction was predicted
    logic [NUM_GHR_BITS-1:0]   pht_index;

    // the side that presents outcomes, it holds everything until ready
    modport producer (
        output valid, pc, target, taken, is_cond, is_jump, pht_index,
        input  ready
    );

    // the init FSM is the only driver of ready
    modport ready_drv (
        output ready
    );

    // the tables only watch the bundle and act on a transfer
    modport consumer (
        input valid, ready, pc, target, taken, is_cond, is_jump, pht_index
    );

endinterface

`default_nettype wire
